// File: hw/aluStage.sv
// Execute stage with operand registers, ALU, redirect logic and the memory-stage result
`timescale 1ns/1ps

module aluStage (
    input  logic        clk,
    input  logic        rst,
    input  logic        advance,
    input  logic [31:0] rsData,
    input  logic [31:0] rtData,
    input  logic [31:0] immExt,
    input  logic [25:0] jumpField,
    input  logic [31:0] pc,
    stageCtrlIf.exec    ctrl,
    output logic        redirectValid,
    output logic [31:0] redirectTarget,
    output logic [31:0] resultM,
    output logic [31:0] storeDataM
);
    import pipePkg::*;

    logic [31:0] rsE, rtE, immE, pcE;
    logic [25:0] jumpE;
    logic [31:0] opB, aluOut, pcPlus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsE   <= '0;
            rtE   <= '0;
            immE  <= '0;
            jumpE <= '0;
            pcE   <= '0;
        end else if (advance) begin
            rsE   <= rsData;
            rtE   <= rtData;
            immE  <= immExt;
            jumpE <= jumpField;
            pcE   <= pc;
        end
    end

    assign opB     = ctrl.ctrlE.aluSrcImm ? immE : rtE;
    assign pcPlus4 = pcE + 32'd4;

    always_comb begin
        case (ctrl.ctrlE.aluOp)
            aluAdd:  aluOut = rsE + opB;
            aluSub:  aluOut = rsE - opB;
            aluSlt:  aluOut = {31'b0, $signed(rsE) < $signed(opB)};
            default: aluOut = rsE ^ opB;
        endcase
    end

    assign redirectValid = ctrl.ctrlE.valid &&
                           ((ctrl.ctrlE.branchNe && rsE != rtE) ||
                            ctrl.ctrlE.jump || ctrl.ctrlE.jumpReg);

    always_comb begin
        if (ctrl.ctrlE.jumpReg) begin
            redirectTarget = rsE;
        end else if (ctrl.ctrlE.jump) begin
            redirectTarget = {pcPlus4[31:28], jumpE, 2'b00}; // Pseudo-direct
        end else begin
            redirectTarget = pcPlus4 + {immE[29:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultM    <= '0;
            storeDataM <= '0;
        end else if (advance) begin
            resultM    <= ctrl.ctrlE.link ? pcE + 32'd8 : aluOut;
            storeDataM <= rtE;
        end
    end

endmodule

// File: hw/dataMem.sv
// Data memory with word-addressed storage and the writeback-stage registers
`timescale 1ns/1ps

module dataMem #(
    parameter int memWords = 256
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,
    input  logic [31:0]     resultM,
    input  logic [31:0]     storeDataM,
    stageCtrlIf.mem         ctrl,
    output logic            storeValid,
    output logic [31:0]     storeAddr,
    output logic [31:0]     storeData,
    output logic            wbValid,
    output isaPkg::regIdxT  wbReg,
    output logic [31:0]     wbData
);
    localparam int addrBits = $clog2(memWords);

    logic [31:0]         mem [memWords];
    logic [addrBits-1:0] wordIdx;
    logic [31:0]         wbDataQ;

    assign wordIdx    = resultM[addrBits+1:2]; // Byte address to word index
    assign storeValid = ctrl.ctrlM.valid && ctrl.ctrlM.memWrite;
    assign storeAddr  = resultM;
    assign storeData  = storeDataM;

    always_ff @(posedge clk) begin
        if (advance && storeValid) begin
            mem[wordIdx] <= storeDataM;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbDataQ <= '0;
        end else if (advance) begin
            wbDataQ <= ctrl.ctrlM.memToReg ? mem[wordIdx] : resultM;
        end
    end

    assign wbValid = ctrl.ctrlW.valid && ctrl.ctrlW.regWrite;
    assign wbReg   = ctrl.ctrlW.destReg;
    assign wbData  = wbDataQ;

    assert property (@(posedge clk) disable iff (rst)
        ctrl.ctrlM.valid && (ctrl.ctrlM.memWrite || ctrl.ctrlM.memToReg)
            |-> resultM[1:0] == 2'b00);

endmodule

// File: hw/execCore.sv
// Execute core top level joining decode, register file, ALU and memory stages
`timescale 1ns/1ps

module execCore #(
    parameter int memWords = 256
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,
    input  logic            instrValid,
    input  logic [31:0]     instr,
    input  logic [31:0]     pc,
    output logic            redirectValid,
    output logic [31:0]     redirectTarget,
    output logic            wbValid,
    output isaPkg::regIdxT  wbReg,
    output logic [31:0]     wbData,
    output logic            storeValid,
    output logic [31:0]     storeAddr,
    output logic [31:0]     storeData
);
    import isaPkg::*;

    regIdxT      rsAddr, rtAddr;
    logic [31:0] rsData, rtData, immExt;
    logic [25:0] jumpField;
    logic [31:0] resultM, storeDataM;

    stageCtrlIf stageCtrl ();

    pipeCtrl uCtrl (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .instrValid (instrValid),
        .instr      (instr),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .immExt     (immExt),
        .jumpField  (jumpField),
        .ctrl       (stageCtrl.ctrl)
    );

    regFile uRegs (
        .clk    (clk),
        .rst    (rst),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .wrAddr (wbReg),
        .wrEn   (wbValid), // Writeback stage drives the write port
        .wrData (wbData),
        .rsData (rsData),
        .rtData (rtData)
    );

    aluStage uAlu (
        .clk            (clk),
        .rst            (rst),
        .advance        (advance),
        .rsData         (rsData),
        .rtData         (rtData),
        .immExt         (immExt),
        .jumpField      (jumpField),
        .pc             (pc),
        .ctrl           (stageCtrl.exec),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget),
        .resultM        (resultM),
        .storeDataM     (storeDataM)
    );

    dataMem #(
        .memWords (memWords)
    ) uMem (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .resultM    (resultM),
        .storeDataM (storeDataM),
        .ctrl       (stageCtrl.mem),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

endmodule

// File: hw/isaPkg.sv
// ISA package with the instruction formats and codes of the MIPS subset
package isaPkg;

    typedef logic [4:0] regIdxT;

    typedef struct packed {
        logic [5:0] opcode;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmtT;

    typedef struct packed {
        logic [5:0]  opcode;
        regIdxT      rs;
        regIdxT      rt;
        logic [15:0] imm;
    } iFmtT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jFmtT;

    // One instruction word, decoded through whichever view fits the opcode
    typedef union packed {
        rFmtT r;
        iFmtT i;
        jFmtT j;
    } instrT;

    localparam logic [5:0] opRType = 6'h00; // Function code selects the operation
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opXori  = 6'h0e;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    localparam logic [5:0] fnJr  = 6'h08;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnSlt = 6'h2a;

    localparam regIdxT linkReg = 5'd31; // Return address for jal

endpackage

// File: hw/pipeCtrl.sv
// Control unit with the instruction decoder and the control pipeline registers
`timescale 1ns/1ps

module pipeCtrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,
    input  logic            instrValid,
    input  isaPkg::instrT   instr,
    output isaPkg::regIdxT  rsAddr,
    output isaPkg::regIdxT  rtAddr,
    output logic [31:0]     immExt,
    output logic [25:0]     jumpField,
    stageCtrlIf.ctrl        ctrl
);
    import isaPkg::*;
    import pipePkg::*;

    ctrlT ctrlD;
    logic known;

    assign rsAddr    = instr.r.rs;
    assign rtAddr    = instr.r.rt;
    assign jumpField = instr.j.target;

    // xori is the only zero-extended immediate
    assign immExt = (instr.i.opcode == opXori) ? {16'b0, instr.i.imm}
                                               : {{16{instr.i.imm[15]}}, instr.i.imm};

    always_comb begin
        ctrlD = '0;
        known = 1'b1;
        case (instr.r.opcode)
            opRType: begin
                ctrlD.destReg = instr.r.rd;
                case (instr.r.funct)
                    fnAdd: begin
                        ctrlD.regWrite = 1'b1;
                        ctrlD.aluOp    = aluAdd;
                    end
                    fnSub: begin
                        ctrlD.regWrite = 1'b1;
                        ctrlD.aluOp    = aluSub;
                    end
                    fnSlt: begin
                        ctrlD.regWrite = 1'b1;
                        ctrlD.aluOp    = aluSlt;
                    end
                    fnJr: begin
                        ctrlD.jumpReg = 1'b1;
                        ctrlD.destReg = '0;
                    end
                    default: known = 1'b0;
                endcase
            end
            opLw: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.memToReg  = 1'b1;
                ctrlD.aluSrcImm = 1'b1; // Address is rs plus offset
                ctrlD.destReg   = instr.i.rt;
            end
            opSw: begin
                ctrlD.memWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
            end
            opXori: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.aluOp     = aluXor;
                ctrlD.destReg   = instr.i.rt;
            end
            opBne: begin
                ctrlD.branchNe = 1'b1;
                ctrlD.aluOp    = aluSub;
            end
            opJ: ctrlD.jump = 1'b1;
            opJal: begin
                ctrlD.jump     = 1'b1;
                ctrlD.link     = 1'b1;
                ctrlD.regWrite = 1'b1;
                ctrlD.destReg  = linkReg;
            end
            default: known = 1'b0;
        endcase
        if (known && instrValid) begin
            ctrlD.valid = 1'b1;
        end else begin
            ctrlD = '0; // Bubble
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.ctrlE <= '0;
            ctrl.ctrlM <= '0;
            ctrl.ctrlW <= '0;
        end else if (advance) begin
            ctrl.ctrlE <= ctrlD;
            ctrl.ctrlM <= ctrl.ctrlE;
            ctrl.ctrlW <= ctrl.ctrlM;
        end
    end

    // Only one kind of redirect per instruction
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctrl.ctrlE.jump, ctrl.ctrlE.jumpReg, ctrl.ctrlE.branchNe}));

    // Bubbles stay harmless all the way down the pipeline
    assert property (@(posedge clk) disable iff (rst)
        !ctrl.ctrlM.valid |-> !ctrl.ctrlM.memWrite && !ctrl.ctrlM.regWrite);
    assert property (@(posedge clk) disable iff (rst)
        !ctrl.ctrlW.valid |-> !ctrl.ctrlW.regWrite);

endmodule

// File: hw/pipePkg.sv
// Pipeline package with the per-stage control word and ALU operations
package pipePkg;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluSlt,
        aluXor
    } aluOpT;

    // Control word that follows an instruction from decode to writeback
    typedef struct packed {
        logic           valid;     // Clear for a bubble
        logic           regWrite;
        logic           memToReg;  // Load data goes to the register file
        logic           memWrite;
        logic           branchNe;
        logic           jump;      // j and jal
        logic           jumpReg;   // jr
        logic           link;      // jal writes pc+8
        logic           aluSrcImm;
        aluOpT          aluOp;
        isaPkg::regIdxT destReg;
    } ctrlT;

endpackage

// File: hw/regFile.sv
// Register file with 32 registers, two read ports and write-through
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  isaPkg::regIdxT  rsAddr,
    input  isaPkg::regIdxT  rtAddr,
    input  isaPkg::regIdxT  wrAddr,
    input  logic            wrEn,
    input  logic [31:0]     wrData,
    output logic [31:0]     rsData,
    output logic [31:0]     rtData
);
    import isaPkg::*;

    logic [31:0] regs [32];
    logic        wrLive;

    assign wrLive = wrEn && wrAddr != regIdxT'(0); // Register 0 ignores writes

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Same-cycle write bypasses the array
    always_comb begin
        if (wrLive && wrAddr == rsAddr) begin
            rsData = wrData;
        end else begin
            rsData = regs[rsAddr];
        end
        if (wrLive && wrAddr == rtAddr) begin
            rtData = wrData;
        end else begin
            rtData = regs[rtAddr];
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        rsAddr == regIdxT'(0) |-> rsData == '0);
    assert property (@(posedge clk) disable iff (rst)
        rtAddr == regIdxT'(0) |-> rtData == '0);

endmodule

// File: hw/stageCtrlIf.sv
// Stage control interface carrying control words from the control unit to the datapath
`timescale 1ns/1ps

interface stageCtrlIf;
    import pipePkg::*;

    ctrlT ctrlE; // Execute stage
    ctrlT ctrlM; // Memory stage
    ctrlT ctrlW; // Writeback stage

    modport ctrl (
        output ctrlE,
        output ctrlM,
        output ctrlW
    );

    modport exec (
        input ctrlE
    );

    modport mem (
        input ctrlM,
        input ctrlW
    );

endinterface

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f vlog.f --top-module execCoreTb -o execCoreSim \
    && ./obj_dir/execCoreSim | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: test/execCoreTb.sv
// Testbench for the execute core, running an instruction table against a reference model
`timescale 1ns/1ps

module execCoreTb;
    import isaPkg::*;

    typedef struct packed {
        logic        adv;
        logic        vld;
        logic [31:0] word;
        logic [31:0] pc;
        logic        redirOn;
        logic [31:0] redirTgt;
        logic        stOn;
        logic [31:0] stAddr;
        logic [31:0] stData;
        logic        wbOn;
        regIdxT      wbDst;
        logic [31:0] wbVal;
    } entryT;

    logic        clk = 1'b0;
    logic        rst, advance, instrValid;
    logic [31:0] instr, pc;
    logic        redirectValid, wbValid, storeValid;
    logic [31:0] redirectTarget, wbData, storeAddr, storeData;
    regIdxT      wbReg;

    entryT       tab[$];
    string       names[$];
    int          entryErrs[$];
    logic [31:0] refRegs [32];                 // Reference register state
    logic [31:0] refMem [logic [31:0]];        // Reference memory by byte address
    int          seed = 32'h47c2_024f;
    int          errors = 0;
    int          testsRun = 0;
    int          testsBad = 0;
    int          cycles = 0;
    int          cycleLimit = 1000;
    int          stE = -1;
    int          stM = -1;
    int          stW = -1;
    logic [31:0] snapTgt, snapAddr, snapData, snapWb;
    regIdxT      snapReg;

    execCore #(.memWords(256)) DUT (
        .clk(clk), .rst(rst), .advance(advance), .instrValid(instrValid),
        .instr(instr), .pc(pc), .redirectValid(redirectValid),
        .redirectTarget(redirectTarget), .wbValid(wbValid), .wbReg(wbReg),
        .wbData(wbData), .storeValid(storeValid), .storeAddr(storeAddr),
        .storeData(storeData)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout after %0d cycles without reaching the end of the table", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] encR(regIdxT rs, regIdxT rt, regIdxT rd, logic [5:0] fn);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(logic [5:0] op, regIdxT rs, regIdxT rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic noteError(input int idx);
        errors++;
        if (idx >= 0) entryErrs[idx]++;
    endtask

    task automatic checkWord(input string sig, input logic [31:0] got,
                             input logic [31:0] exp, input int idx);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, sig, got, exp);
            noteError(idx);
        end
    endtask

    task automatic checkReg(input string sig, input regIdxT got, input regIdxT exp,
                            input int idx);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, sig, got, exp);
            noteError(idx);
        end
    endtask

    task automatic checkBit(input string sig, input logic got, input logic exp, input int idx);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, sig, got, exp);
            noteError(idx);
        end
    endtask

    task automatic pushEntry(input string name, input entryT e);
        tab.push_back(e);
        names.push_back(name);
        entryErrs.push_back(0);
    endtask

    task automatic addBubbles(input int count);
        entryT e;
        for (int k = 0; k < count; k++) begin
            e = '0;
            e.adv  = 1'b1;
            e.word = $random(seed); // Ignored since instrValid is low
            pushEntry("bubble", e);
        end
    endtask

    // Random stall cycles presenting a valid-looking word that must not be taken
    task automatic addStalls();
        entryT e;
        int    count;
        count = $random(seed) & 3;
        for (int k = 0; k < count; k++) begin
            e = '0;
            e.vld  = 1'b1;
            e.word = encR(5'd1, 5'd2, 5'd20, fnAdd);
            e.pc   = $random(seed);
            pushEntry("stall", e);
        end
    endtask

    // Reference model of the instruction rules, then the entry and its spacing
    task automatic addInstr(input string name, input logic [31:0] word,
                            input logic [31:0] pcVal, input int gap);
        entryT       e;
        logic [31:0] a, b, sImm, zImm, pc4;
        e = '0;
        e.adv  = 1'b1;
        e.vld  = 1'b1;
        e.word = word;
        e.pc   = pcVal;
        a    = refRegs[word[25:21]];
        b    = refRegs[word[20:16]];
        sImm = {{16{word[15]}}, word[15:0]};
        zImm = {16'd0, word[15:0]};
        pc4  = pcVal + 32'd4;
        case (word[31:26])
            opRType: begin
                e.wbDst = word[15:11];
                case (word[5:0])
                    fnAdd: {e.wbOn, e.wbVal} = {1'b1, a + b};
                    fnSub: {e.wbOn, e.wbVal} = {1'b1, a - b};
                    fnSlt: {e.wbOn, e.wbVal} = {1'b1, 31'd0, $signed(a) < $signed(b)};
                    fnJr:  {e.redirOn, e.redirTgt} = {1'b1, a};
                    default: e.wbDst = '0;
                endcase
            end
            opLw: begin
                e.wbOn  = 1'b1;
                e.wbDst = word[20:16];
                e.wbVal = refMem[a + sImm];
            end
            opSw: begin
                {e.stOn, e.stAddr, e.stData} = {1'b1, a + sImm, b};
                refMem[a + sImm] = b;
            end
            opXori: {e.wbOn, e.wbDst, e.wbVal} = {1'b1, word[20:16], a ^ zImm};
            opBne: {e.redirOn, e.redirTgt} = {a != b, pc4 + {sImm[29:0], 2'b00}};
            opJ: {e.redirOn, e.redirTgt} = {1'b1, pc4[31:28], word[25:0], 2'b00};
            opJal: begin
                {e.redirOn, e.redirTgt} = {1'b1, pc4[31:28], word[25:0], 2'b00};
                {e.wbOn, e.wbDst, e.wbVal} = {1'b1, 5'd31, pcVal + 32'd8};
            end
            default: e.wbDst = '0; // Undefined opcode has no effect
        endcase
        if (e.wbOn && e.wbDst != 5'd0) refRegs[e.wbDst] = e.wbVal;
        pushEntry(name, e);
        addStalls();
        addBubbles(gap);
    endtask

    task automatic reportTest(input int idx);
        testsRun++;
        if (entryErrs[idx] != 0) testsBad++;
        $display("test %0d %s: %s", testsRun, names[idx], entryErrs[idx] == 0 ? "ok" : "mismatch");
    endtask

    task automatic shiftStages(input int idx);
        if (stW >= 0) reportTest(stW);
        stW = stM;
        stM = stE;
        stE = tab[idx].vld ? idx : -1;
    endtask

    task automatic checkOutputs(input logic lastStall);
        logic eRedir, eStore, eWb;
        eRedir = stE >= 0 && tab[stE].redirOn;
        eStore = stM >= 0 && tab[stM].stOn;
        eWb    = stW >= 0 && tab[stW].wbOn;
        checkBit("redirectValid", redirectValid, eRedir, stE);
        checkBit("storeValid", storeValid, eStore, stM);
        checkBit("wbValid", wbValid, eWb, stW);
        if (eRedir) checkWord("redirectTarget", redirectTarget, tab[stE].redirTgt, stE);
        if (eStore) checkWord("storeAddr", storeAddr, tab[stM].stAddr, stM);
        if (eStore) checkWord("storeData", storeData, tab[stM].stData, stM);
        if (eWb) checkReg("wbReg", wbReg, tab[stW].wbDst, stW);
        if (eWb) checkWord("wbData", wbData, tab[stW].wbVal, stW);
        if (lastStall) begin // Nothing may move on a stalled edge
            checkWord("redirectTarget", redirectTarget, snapTgt, -1);
            checkWord("storeAddr", storeAddr, snapAddr, -1);
            checkWord("storeData", storeData, snapData, -1);
            checkReg("wbReg", wbReg, snapReg, -1);
            checkWord("wbData", wbData, snapWb, -1);
        end
        {snapTgt, snapAddr, snapData, snapReg, snapWb} =
            {redirectTarget, storeAddr, storeData, wbReg, wbData};
    endtask

    initial begin
        logic [15:0] rndImm;
        rst        = 1'b1;
        advance    = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        for (int k = 0; k < 32; k++) refRegs[k] = '0;
        rndImm = $random(seed);
        addInstr("xori zero-extends", encI(opXori, 5'd0, 5'd1, 16'h8001), 32'h100, 0);
        addInstr("xori small", encI(opXori, 5'd0, 5'd2, 16'h0005), 32'h104, 0);
        addInstr("xori random imm", encI(opXori, 5'd0, 5'd3, rndImm), 32'h108, 2);
        addInstr("add", encR(5'd1, 5'd2, 5'd4, fnAdd), 32'h10c, 0);
        addInstr("sub negative", encR(5'd2, 5'd1, 5'd5, fnSub), 32'h110, 0);
        addInstr("write to r0", encI(opXori, 5'd1, 5'd0, 16'h00ff), 32'h114, 2);
        addInstr("slt negative", encR(5'd5, 5'd2, 5'd6, fnSlt), 32'h118, 0);
        addInstr("slt false", encR(5'd2, 5'd5, 5'd7, fnSlt), 32'h11c, 0);
        addInstr("add reads r0", encR(5'd0, 5'd3, 5'd8, fnAdd), 32'h120, 2);
        addInstr("sw r4", encI(opSw, 5'd0, 5'd4, 16'h0040), 32'h124, 0);
        addInstr("sw r5", encI(opSw, 5'd0, 5'd5, 16'h0048), 32'h128, 0);
        addInstr("lw after sw", encI(opLw, 5'd0, 5'd9, 16'h0040), 32'h12c, 0);
        addInstr("lw second", encI(opLw, 5'd0, 5'd10, 16'h0048), 32'h130, 2);
        addInstr("bne taken", encI(opBne, 5'd1, 5'd2, 16'h0003), 32'h134, 0);
        addInstr("bne not taken", encI(opBne, 5'd1, 5'd1, 16'hfffe), 32'h138, 0);
        addInstr("j", {opJ, 26'h0000040}, 32'h13c, 0);
        addInstr("jal", {opJal, 26'h0000123}, 32'h140, 0);
        addInstr("jr", encR(5'd4, 5'd0, 5'd0, fnJr), 32'h144, 2);
        addInstr("undefined opcode", encI(6'h3f, 5'd1, 5'd12, 16'h1234), 32'h148, 0);
        addInstr("undefined funct", encR(5'd1, 5'd2, 5'd13, 6'h3f), 32'h14c, 0);
        addInstr("add reads link", encR(5'd31, 5'd13, 5'd11, fnAdd), 32'h150, 0);
        addBubbles(4); // Drain the pipeline
        cycleLimit = tab.size() + 20;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkOutputs(1'b0);
        for (int i = 0; i <= tab.size(); i++) begin
            @(posedge clk);
            if (i > 0 && tab[i-1].adv) shiftStages(i - 1);
            if (i < tab.size()) begin
                advance    <= tab[i].adv;
                instrValid <= tab[i].vld;
                instr      <= tab[i].word;
                pc         <= tab[i].pc;
            end
            @(negedge clk);
            checkOutputs(i > 0 && !tab[i-1].adv);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 testsRun, testsRun - testsBad, testsBad, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/isaPkg.sv
hw/pipePkg.sv
hw/stageCtrlIf.sv
hw/pipeCtrl.sv
hw/regFile.sv
hw/aluStage.sv
hw/dataMem.sv
hw/execCore.sv
test/execCoreTb.sv
